/* build.f */
+incdir+include
rtl/axi_chk_pkg.sv
rtl/chan_fifo.sv
rtl/beat_addr_gen.sv
rtl/strb_last_check.sv
rtl/axi_wr_checker.sv
test/axi_wr_checker_checker.sv
test/axi_wr_checker_tb.sv

/* include/axi_chk_config.svh */
/*
 * AXI4 write monitor configuration
 * Bus geometry and queue depths shared by the package and the top level
 */

`ifndef AXI_CHK_CONFIG_SVH
`define AXI_CHK_CONFIG_SVH

// Write address width in bits
`define AXI_CHK_ADDR_W 32

`define AXI_CHK_STRB_W 8  // Byte lanes of a 64-bit data bus

// Depth of the AW and W queues
`define AXI_CHK_AW_DEPTH 4
`define AXI_CHK_W_DEPTH  4

`endif

/* rtl/axi_chk_pkg.sv */
/*
 * AXI4 write monitor types
 * Accepted AW commands, W beats, per-beat lane requests and beat reports
 */

`default_nettype none

`include "axi_chk_config.svh"

package axi_chk_pkg;

   localparam int ADDR_W = `AXI_CHK_ADDR_W;
   localparam int STRB_W = `AXI_CHK_STRB_W;
   localparam int LANE_W = $clog2(`AXI_CHK_STRB_W);  // Bits to index one byte lane

   // AXI4 AWBURST encodings, 2'b11 is reserved
   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } burst_e;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;   // AWADDR
      logic [7:0]        len;    // AWLEN, beats minus one
      logic [2:0]        size;   // AWSIZE, log2 of transfer bytes
      burst_e            burst;  // AWBURST
   } aw_cmd_t;

   typedef struct packed {
      logic [STRB_W-1:0] strb;  // WSTRB
      logic              last;  // WLAST
   } w_beat_t;

   // One W beat paired with the window its command allows
   typedef struct packed {
      logic [LANE_W-1:0] lower_lane;
      logic [LANE_W-1:0] upper_lane;
      logic              last_expected;  // Beat count equals AWLEN
      logic [STRB_W-1:0] strb;
      logic              last;
   } lane_req_t;

   typedef struct packed {
      logic [7:0] beat_num;  // Position within the burst, from 0
      logic       strb_err;
      logic       last_err;
   } beat_report_t;

endpackage

`default_nettype wire

/* rtl/axi_wr_checker.sv */
/*
 * AXI4 write channel monitor
 * Passively queues AW and W, pairs them in AW order and reports
 * strobe window and WLAST errors per beat
 */

`default_nettype none

`include "axi_chk_config.svh"

module axi_wr_checker
   import axi_chk_pkg::*;
(
   input  logic         axi_assert,
   input  logic         rst_n,
   input  logic         aw_valid,
   input  logic         aw_ready,
   input  aw_cmd_t      aw,
   input  logic         w_valid,
   input  logic         w_ready,
   input  w_beat_t      w,
   output logic         report_valid,
   output beat_report_t report,
   output logic         error_seen,
   output logic         overflow     // Sticky, some AW or W item was dropped
);

   logic      cmd_valid;
   logic      cmd_ready;
   aw_cmd_t   cmd;
   logic      beat_valid;
   logic      beat_ready;
   w_beat_t   beat;
   logic      aw_ovf;
   logic      w_ovf;
   logic      req_valid;
   lane_req_t req;

   chan_fifo #(.payload_t(aw_cmd_t), .depth(`AXI_CHK_AW_DEPTH)) aw_fifo (
      .axi_assert, .rst_n,
      .in_valid(aw_valid && aw_ready), .in_data(aw),      // Handshake seen on the bus
      .out_ready(cmd_ready), .in_full(), .out_valid(cmd_valid),
      .out_data(cmd), .overflow_pulse(aw_ovf));

   chan_fifo #(.payload_t(w_beat_t), .depth(`AXI_CHK_W_DEPTH)) w_fifo (
      .axi_assert, .rst_n,
      .in_valid(w_valid && w_ready), .in_data(w),
      .out_ready(beat_ready), .in_full(), .out_valid(beat_valid),
      .out_data(beat), .overflow_pulse(w_ovf));

   beat_addr_gen u_beat_addr_gen (
      .axi_assert, .rst_n, .cmd_valid, .cmd, .beat_valid, .beat,
      .cmd_ready, .beat_ready, .req_valid, .req);

   strb_last_check u_strb_last_check (
      .axi_assert, .rst_n, .req_valid, .req, .report_valid, .report, .error_seen);

   // Either queue losing an item latches overflow
   always_ff @(posedge axi_assert or negedge rst_n) begin
      if (!rst_n)
         overflow <= 1'b0;
      else
         overflow <= overflow | aw_ovf | w_ovf;
   end

endmodule

`default_nettype wire

/* rtl/beat_addr_gen.sv */
/*
 * Beat address generator
 * Walks the head AW burst beat by beat against the W queue, giving each
 * beat its legal byte-lane window and whether WLAST is due on it
 */

`default_nettype none

module beat_addr_gen
   import axi_chk_pkg::*;
(
   input  logic      axi_assert,
   input  logic      rst_n,
   input  logic      cmd_valid,
   input  aw_cmd_t   cmd,
   input  logic      beat_valid,
   input  w_beat_t   beat,
   output logic      cmd_ready,
   output logic      beat_ready,
   output logic      req_valid,
   output lane_req_t req
);

   logic [7:0]        beat_cnt;      // Beats already paired in the head burst
   logic [ADDR_W-1:0] cur_addr;      // Address of the next beat after the first
   logic [ADDR_W-1:0] wrap_base;     // Lower wrap boundary of the head burst
   logic              first_beat;
   logic              pair;
   logic              final_beat;
   logic [ADDR_W-1:0] beat_addr;
   logic [ADDR_W-1:0] xfer_bytes;
   logic [ADDR_W-1:0] size_mask;
   logic [ADDR_W-1:0] aligned_addr;
   logic [ADDR_W-1:0] incr_addr;
   logic [ADDR_W-1:0] wrap_bytes;
   logic [ADDR_W-1:0] start_base;
   logic [ADDR_W-1:0] base_addr;
   logic [ADDR_W-1:0] next_addr;
   logic [LANE_W-1:0] lower_lane;
   logic [LANE_W-1:0] upper_lane;

   // First beat takes its address straight from the head command
   // so pairing costs no extra cycle
   always_comb begin
      first_beat   = (beat_cnt == 8'd0);
      beat_addr    = first_beat ? cmd.addr : cur_addr;
      xfer_bytes   = ADDR_W'(1) << cmd.size;     // S, never wider than the bus
      size_mask    = xfer_bytes - ADDR_W'(1);
      aligned_addr = beat_addr & ~size_mask;
      incr_addr    = aligned_addr + xfer_bytes;

      // Wrap span is S times (len+1)
      wrap_bytes = (ADDR_W'(cmd.len) + ADDR_W'(1)) << cmd.size;
      start_base = cmd.addr & ~(wrap_bytes - ADDR_W'(1));
      base_addr  = first_beat ? start_base : wrap_base;

      lower_lane = beat_addr[LANE_W-1:0];                                 // A mod NB
      upper_lane = aligned_addr[LANE_W-1:0] + size_mask[LANE_W-1:0];  // Top lane of transfer

      case (cmd.burst)
         FIXED:   next_addr = beat_addr;
         WRAP:    next_addr = (incr_addr == base_addr + wrap_bytes) ? base_addr : incr_addr;
         default: next_addr = incr_addr;    // INCR, reserved treated alike
      endcase
   end

   assign pair       = cmd_valid && beat_valid;
   assign final_beat = (beat_cnt == cmd.len);   // Count reaches AWLEN
   assign beat_ready = pair;
   assign cmd_ready  = pair && final_beat;      // Command leaves with its last beat

   // Burst progress
   always_ff @(posedge axi_assert or negedge rst_n) begin
      if (!rst_n) begin
         beat_cnt  <= 8'd0;
         req_valid <= 1'b0;
      end else begin
         req_valid <= pair;
         if (pair)
            beat_cnt <= final_beat ? 8'd0 : beat_cnt + 8'd1;
      end
   end

   // Address state and request payload
   always_ff @(posedge axi_assert) begin
      if (pair) begin
         cur_addr          <= next_addr;
         wrap_base         <= base_addr;
         req.lower_lane    <= lower_lane;
         req.upper_lane    <= upper_lane;
         req.last_expected <= final_beat;
         req.strb          <= beat.strb;
         req.last          <= beat.last;
      end
   end

endmodule

`default_nettype wire

/* rtl/chan_fifo.sv */
/*
 * Channel queue for the write monitor
 * Circular buffer that never stalls its producer and flags dropped items
 */

`default_nettype none

module chan_fifo #(
   parameter type payload_t = logic,
   parameter int  depth     = 4
) (
   input  logic     axi_assert,
   input  logic     rst_n,
   input  logic     in_valid,       // Producer never waits, so valid alone writes
   input  payload_t in_data,
   input  logic     out_ready,
   output logic     in_full,
   output logic     out_valid,
   output payload_t out_data,
   output logic     overflow_pulse  // Accept arrived while full, item lost
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t           mem [depth];
   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;
   logic [cnt_w-1:0]   count;
   logic               push;
   logic               pop;

   assign in_full        = (count == cnt_w'(depth));
   assign out_valid      = (count != '0);
   assign out_data       = mem[rd_ptr];     // Head shows one cycle after its write
   assign push           = in_valid && !in_full;
   assign pop            = out_valid && out_ready;
   assign overflow_pulse = in_valid && in_full;

   // Pointers and occupancy
   always_ff @(posedge axi_assert or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // Storage
   always_ff @(posedge axi_assert) begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

endmodule

`default_nettype wire

/* rtl/strb_last_check.sv */
/*
 * Strobe and WLAST check stage
 * Registers one report per beat and holds a sticky error flag
 */

`default_nettype none

module strb_last_check
   import axi_chk_pkg::*;
(
   input  logic         axi_assert,
   input  logic         rst_n,
   input  logic         req_valid,
   input  lane_req_t    req,
   output logic         report_valid,
   output beat_report_t report,
   output logic         error_seen    // Sticky until reset
);

   logic       strb_err;
   logic       last_err;
   logic [7:0] beat_cnt;     // Position of the incoming beat in its burst

   // Any strobe outside [lower_lane, upper_lane] is illegal
   always_comb begin
      strb_err = 1'b0;
      for (int i = 0; i < STRB_W; i++) begin
         if ((i < int'(req.lower_lane) || i > int'(req.upper_lane)) && req.strb[i])
            strb_err = 1'b1;
      end
      last_err = (req.last != req.last_expected);
   end

   always_ff @(posedge axi_assert or negedge rst_n) begin
      if (!rst_n) begin
         report_valid <= 1'b0;
         error_seen   <= 1'b0;
         beat_cnt     <= 8'd0;
      end else begin
         report_valid <= req_valid;
         if (req_valid) begin
            beat_cnt   <= req.last_expected ? 8'd0 : beat_cnt + 8'd1;  // Follows AWLEN
            error_seen <= error_seen | strb_err | last_err;
         end
      end
   end

   always_ff @(posedge axi_assert) begin
      if (req_valid) begin
         report.beat_num <= beat_cnt;
         report.strb_err <= strb_err;
         report.last_err <= last_err;
      end
   end

endmodule

`default_nettype wire

/* test/axi_wr_checker_checker.sv */
/*
 * Protocol assertions for the AXI4 write monitor outputs
 * Bound onto the top level to watch reset, X and sticky flag behavior
 */

`default_nettype none

module axi_wr_checker_checker
   import axi_chk_pkg::*;
(
   input logic         axi_assert,
   input logic         rst_n,
   input logic         report_valid,
   input beat_report_t report,
   input logic         error_seen,
   input logic         overflow
);

   timeunit 1ns;
   timeprecision 100ps;

   // No report may leave while in reset
   report_quiet_in_reset: assert property (@(posedge axi_assert) !rst_n |-> !report_valid)
      else $error("report_valid high during reset");

   report_known: assert property (@(posedge axi_assert) disable iff (!rst_n)
      report_valid |-> !$isunknown(report))
      else $error("report carries X while report_valid is high");

   // Both flags are sticky until the next reset
   error_seen_sticky: assert property (@(posedge axi_assert) disable iff (!rst_n)
      error_seen |=> error_seen)
      else $error("error_seen dropped without reset");

   overflow_sticky: assert property (@(posedge axi_assert) disable iff (!rst_n)
      overflow |=> overflow)
      else $error("overflow dropped without reset");

endmodule

`default_nettype wire

/* test/axi_wr_checker_tb.sv */
/*
 * Testbench for the AXI4 write monitor
 * Drives a table of AW/W bursts and matches each beat report against
 * the strobe window and WLAST rules of AXI4
 */

`default_nettype none

module axi_wr_checker_tb
   import axi_chk_pkg::*;
;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_ROWS       = 15;
   localparam int REPORT_TIMEOUT = 20;   // Cycles allowed per report

   // Command fields only matter on a burst's first row
   typedef struct packed {
      aw_cmd_t           cmd;
      logic [STRB_W-1:0] strb;
      logic              last;
      logic              aw_late;  // AW follows the first W beat
   } row_t;

   localparam aw_cmd_t NO_CMD = '0;

   logic         axi_assert = 1'b0;
   logic         rst_n;
   logic         aw_valid;
   logic         aw_ready;
   aw_cmd_t      aw;
   logic         w_valid;
   logic         w_ready;
   w_beat_t      w;
   logic         report_valid;
   beat_report_t report;
   logic         error_seen;
   logic         overflow;

   beat_report_t exp_q [$];   // Expected reports in AW order
   int           reports_seen = 0;

   row_t rows [NUM_ROWS] = '{
      '{'{32'h0000_1000, 8'd3, 3'd3, INCR}, 8'hff, 1'b0, 1'b0},  // Aligned INCR with no errors
      '{NO_CMD, 8'hff, 1'b0, 1'b0},
      '{NO_CMD, 8'hff, 1'b0, 1'b0},
      '{NO_CMD, 8'hff, 1'b1, 1'b0},
      '{'{32'h0000_2003, 8'd1, 3'd2, INCR}, 8'h0c, 1'b0, 1'b0},  // Unaligned start bars lane 2
      '{NO_CMD, 8'hf0, 1'b1, 1'b0},
      '{'{32'h0000_3004, 8'd1, 3'd1, FIXED}, 8'h30, 1'b0, 1'b0},
      '{NO_CMD, 8'h70, 1'b1, 1'b0},                              // Lane 6 outside window
      '{'{32'h0000_400c, 8'd3, 3'd2, WRAP}, 8'hf0, 1'b0, 1'b0},  // Wraps to 0x4000
      '{NO_CMD, 8'h0f, 1'b0, 1'b0},
      '{NO_CMD, 8'hf0, 1'b1, 1'b0},                              // WLAST one beat early
      '{NO_CMD, 8'h0f, 1'b0, 1'b0},                              // WLAST missing
      '{'{32'h0000_5000, 8'd1, 3'd3, INCR}, 8'hff, 1'b0, 1'b1},  // W before AW
      '{NO_CMD, 8'hff, 1'b1, 1'b0},
      '{'{32'h0000_6005, 8'd0, 3'd0, INCR}, 8'h20, 1'b1, 1'b1}   // Single beat with W first
   };

   axi_wr_checker axi_wr_checker_i (.*);

   bind axi_wr_checker axi_wr_checker_checker checker_i (.*);

   always #50 axi_assert = ~axi_assert;   // 100 ns period

   // Every report the DUT raises, matched or not
   always @(negedge axi_assert)
      if (rst_n === 1'b1 && report_valid === 1'b1)
         reports_seen++;

   task automatic stop_on_failure(string line);
      $display("%s", line);
      $display("Testbench failed");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_report(beat_report_t got, beat_report_t exp, int idx);
      if (got !== exp)
         stop_on_failure($sformatf(
            "FAILED at %0t ns: report %0d got beat %0d strb_err %b last_err %b, expected %0d %b %b",
            $time, idx, got.beat_num, got.strb_err, got.last_err,
            exp.beat_num, exp.strb_err, exp.last_err));
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp)
         stop_on_failure($sformatf("FAILED at %0t ns: %s is %b, expected %b",
                                   $time, name, got, exp));
   endtask

   // Expected result for beat n of a burst by the AXI4 address rules
   function automatic beat_report_t expect_beat(aw_cmd_t c, int n, w_beat_t b);
      int unsigned       nbytes;
      int unsigned       total;
      int unsigned       base;
      int unsigned       addr;
      int unsigned       lo;
      int unsigned       hi;
      logic [STRB_W-1:0] allowed;
      beat_report_t      r;
      nbytes = 1 << c.size;
      total  = nbytes * (int'(c.len) + 1);
      base   = (c.addr / total) * total;            // Wrap boundary
      if (c.burst == FIXED || n == 0)
         addr = c.addr;
      else
         addr = (c.addr / nbytes) * nbytes + n * nbytes;
      if (c.burst == WRAP && addr >= base + total)
         addr = addr - total;
      lo = addr % STRB_W;
      hi = ((addr / nbytes) * nbytes) % STRB_W + nbytes - 1;
      allowed = '0;
      for (int i = lo; i <= hi; i++)
         allowed[i] = 1'b1;
      r.beat_num = 8'(n);
      r.strb_err = |(b.strb & ~allowed);
      r.last_err = (b.last != (n == int'(c.len)));
      return r;
   endfunction

   task automatic build_expected();
      aw_cmd_t cur;
      w_beat_t b;
      int      beat_idx;
      beat_idx = 0;
      cur = '0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         if (beat_idx == 0)
            cur = rows[i].cmd;
         b.strb = rows[i].strb;
         b.last = rows[i].last;
         exp_q.push_back(expect_beat(cur, beat_idx, b));
         beat_idx = (beat_idx == int'(cur.len)) ? 0 : beat_idx + 1;
      end
   endtask

   // One bus cycle with inputs changing 10 ns after the edge
   task automatic apply(logic aw_v, aw_cmd_t c, logic w_v, w_beat_t b);
      aw_valid = aw_v;
      aw       = c;
      w_valid  = w_v;
      w        = b;
      @(posedge axi_assert);
      #10;
   endtask

   task automatic drive_table();
      aw_cmd_t cur;
      w_beat_t b;
      int      beat_idx;
      beat_idx = 0;
      cur = '0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         b.strb = rows[i].strb;
         b.last = rows[i].last;
         if (beat_idx == 0) begin
            cur = rows[i].cmd;
            if (rows[i].aw_late) begin
               apply(1'b0, cur, 1'b1, b);   // Beat queues with no command yet
               apply(1'b1, cur, 1'b0, b);
            end else begin
               apply(1'b1, cur, 1'b1, b);
            end
         end else begin
            apply(1'b0, cur, 1'b1, b);
         end
         beat_idx = (beat_idx == int'(cur.len)) ? 0 : beat_idx + 1;
      end
      aw_valid = 1'b0;
      w_valid  = 1'b0;
   endtask

   // Sampled on the falling edge where registered outputs are settled
   task automatic collect_reports();
      int           total;
      int           waited;
      logic         err_sticky;
      beat_report_t exp;
      total = exp_q.size();
      err_sticky = 1'b0;
      for (int k = 0; k < total; k++) begin
         waited = 0;
         @(negedge axi_assert);
         while (report_valid !== 1'b1 && waited < REPORT_TIMEOUT) begin
            @(negedge axi_assert);
            waited++;
         end
         if (report_valid !== 1'b1)
            stop_on_failure($sformatf("Timed out waiting for report %0d of %0d", k, total));
         exp = exp_q.pop_front();
         check_report(report, exp, k);
         err_sticky = err_sticky | exp.strb_err | exp.last_err;
         check_flag("error_seen", error_seen, err_sticky);
      end
   endtask

   initial begin
      aw_cmd_t ovf_cmd;
      w_beat_t idle_beat;
      void'($urandom(32'hd906));
      rst_n     = 1'b0;
      aw_valid  = 1'b0;
      aw_ready  = 1'b1;           // Monitor sees a bus that always accepts
      aw        = '0;
      w_valid   = 1'b0;
      w_ready   = 1'b1;
      w         = '0;
      idle_beat = '0;
      repeat (5) @(posedge axi_assert);
      #10;
      rst_n = 1'b1;

      check_flag("report_valid", report_valid, 1'b0);
      check_flag("error_seen", error_seen, 1'b0);
      check_flag("overflow", overflow, 1'b0);

      build_expected();
      fork
         drive_table();
         collect_reports();
      join
      @(posedge axi_assert);      // Back in step with the stimulus phase
      #10;
      check_flag("overflow", overflow, 1'b0);

      // Fifth of five data-less commands meets a full AW queue
      for (int k = 0; k < 5; k++) begin
         ovf_cmd.addr  = $urandom() & 32'hffff_fff8;
         ovf_cmd.len   = 8'd0;
         ovf_cmd.size  = 3'd3;
         ovf_cmd.burst = INCR;
         apply(1'b1, ovf_cmd, 1'b0, idle_beat);
      end
      aw_valid = 1'b0;
      @(posedge axi_assert);
      #10;
      check_flag("overflow", overflow, 1'b1);
      check_flag("error_seen", error_seen, 1'b1);
      check_flag("report_valid", report_valid, 1'b0);   // Commands alone pair with nothing

      if (reports_seen == NUM_ROWS) begin
         $display("Testbench passed");
         $finish;
      end else begin
         stop_on_failure($sformatf("FAILED at %0t ns: saw %0d reports for %0d table rows",
                                   $time, reports_seen, NUM_ROWS));
      end
   end

endmodule

`default_nettype wire
